// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_axis_conv_engine
FILELIST  := list.f
PASS_MSG  := ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: include/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// array shape
`define CONV_CORES 2
`define CONV_UNITS 4

// signed word widths
`define CONV_WORD_IN 8
`define CONV_WORD_ACC 24

// enabled cycles from the operand registers to the product
`define CONV_LAT_MUL 2

`endif

// File: list.f
+incdir+include
logic/conv_pkg.sv
logic/mac_unit.sv
logic/conv_engine.sv
logic/axis_out_slice.sv
logic/axis_conv_engine.sv
tb/axis_conv_engine_assert.sv
tb/tb_axis_conv_engine.sv

// File: logic/axis_conv_engine.sv
`timescale 1ns/1ps

module axis_conv_engine (
  input  logic                 aclk,
  input  logic                 reset,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  logic                 s_last,
  input  conv_pkg::conv_user_t s_user,
  input  conv_pkg::conv_in_t   s_data,
  output logic                 m_valid,
  input  logic                 m_ready,
  output logic                 m_last,
  output conv_pkg::conv_user_t m_user,
  output conv_pkg::conv_out_t  m_data
);

  import conv_pkg::*;

  // slice ready doubles as the engine clock enable
  logic       clken;
  logic       eng_valid;
  logic       eng_last;
  conv_beat_t eng_beat;
  conv_beat_t out_beat;

  conv_engine engine_i (
    .aclk    (aclk),
    .reset   (reset),
    .clken   (clken),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_last  (s_last),
    .s_user  (s_user),
    .s_data  (s_data),
    .m_valid (eng_valid),
    .m_last  (eng_last),
    .m_beat  (eng_beat)
  );

  axis_out_slice slice_i (
    .aclk    (aclk),
    .reset   (reset),
    .s_valid (eng_valid),
    .s_ready (clken),
    .s_last  (eng_last),
    .s_beat  (eng_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_last  (m_last),
    .m_beat  (out_beat)
  );

  assign m_user = out_beat.user;
  assign m_data = out_beat.data;

endmodule

// File: logic/axis_out_slice.sv
`timescale 1ns/1ps

module axis_out_slice (
  input  logic                 aclk,
  input  logic                 reset,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  logic                 s_last,
  input  conv_pkg::conv_beat_t s_beat,
  output logic                 m_valid,
  input  logic                 m_ready,
  output logic                 m_last,
  output conv_pkg::conv_beat_t m_beat
);

  import conv_pkg::*;

  slice_state_t state_q;
  conv_beat_t   main_beat;
  conv_beat_t   skid_beat;
  logic         main_last;
  logic         skid_last;
  logic         push;
  logic         pop;

  // ready only depends on the state, so it never loops back through m_ready
  assign s_ready = (state_q != FULL);
  assign m_valid = (state_q != EMPTY);
  assign m_last  = m_valid && main_last;
  assign m_beat  = main_beat;

  assign push = s_valid && s_ready;
  assign pop  = m_valid && m_ready;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state_q <= EMPTY;
    end else begin
      case (state_q)
        EMPTY: if (push) state_q <= ONE;
        ONE: begin
          if (push && !pop) begin
            state_q <= FULL;
          end else if (!push && pop) begin
            state_q <= EMPTY;
          end
        end
        FULL: if (pop) state_q <= ONE;
        default: state_q <= EMPTY;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if ((state_q == EMPTY && push) || (state_q == ONE && push && pop)) begin
      main_beat <= s_beat;
      main_last <= s_last;
    end else if (state_q == ONE && push) begin
      skid_beat <= s_beat;
      skid_last <= s_last;
    end else if (state_q == FULL && pop) begin
      main_beat <= skid_beat;
      main_last <= skid_last;
    end
  end

endmodule

// File: logic/conv_engine.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module conv_engine #(
  parameter int CORES = `CONV_CORES,
  parameter int UNITS = `CONV_UNITS
) (
  input  logic                  aclk,
  input  logic                  reset,
  input  logic                  clken,
  input  logic                  s_valid,
  output logic                  s_ready,
  input  logic                  s_last,
  input  conv_pkg::conv_user_t  s_user,
  input  conv_pkg::conv_in_t    s_data,
  output logic                  m_valid,
  output logic                  m_last,
  output conv_pkg::conv_beat_t  m_beat
);

  import conv_pkg::*;

  // operand register, multiplier stages, accumulator
  localparam int DEPTH = `CONV_LAT_MUL + 2;

  logic                             accept;
  logic                             fresh_q;
  logic [DEPTH-1:0]                 last_q;
  conv_user_t                       user_q [DEPTH];
  logic signed [`CONV_WORD_ACC-1:0] cell_sum [CORES][UNITS];

  // the whole pipeline stalls with the output slice
  assign s_ready = clken;
  assign accept  = s_valid && clken;

  // first beat after reset or after a last beat opens a new sum
  always_ff @(posedge aclk) begin
    if (reset) begin
      fresh_q <= 1'b1;
    end else if (accept) begin
      fresh_q <= s_last;
    end
  end

  // end-of-group strobe aligned with the accumulator update
  always_ff @(posedge aclk) begin
    if (reset) begin
      last_q <= '0;
    end else if (clken) begin
      last_q <= {last_q[DEPTH-2:0], accept && s_last};
    end
  end

  always_ff @(posedge aclk) begin
    if (clken) begin
      user_q[0] <= s_user;
      for (int i = 1; i < DEPTH; i++) begin
        user_q[i] <= user_q[i-1];
      end
    end
  end

  for (genvar gc = 0; gc < CORES; gc++) begin : g_core
    for (genvar gu = 0; gu < UNITS; gu++) begin : g_unit
      mac_unit mac_i (
        .aclk    (aclk),
        .reset   (reset),
        .clken   (clken),
        .pixel   (s_data.pixels[gu]),
        .weight  (s_data.weights[gc]),
        .en      (accept),
        .restart (fresh_q),
        .sum     (cell_sum[gc][gu])
      );
    end
  end

  assign m_valid = last_q[DEPTH-1];
  // every output beat closes a group
  assign m_last  = last_q[DEPTH-1];

  always_comb begin
    m_beat      = '0;
    m_beat.user = user_q[DEPTH-1];
    for (int c = 0; c < CORES; c++) begin
      for (int u = 0; u < UNITS; u++) begin
        m_beat.data.sums[c][u] = cell_sum[c][u];
      end
    end
  end

endmodule

// File: logic/conv_pkg.sv
`include "conv_macros.svh"

package conv_pkg;

  // sideband for the activation and pooling blocks downstream
  typedef struct packed {
    logic is_lrelu;
    logic is_max;
  } conv_user_t;

  // one input beat with a pixel per unit and a weight per core
  typedef struct packed {
    logic [`CONV_UNITS-1:0][`CONV_WORD_IN-1:0] pixels;
    logic [`CONV_CORES-1:0][`CONV_WORD_IN-1:0] weights;
  } conv_in_t;

  // sums indexed [core][unit]
  typedef struct packed {
    logic [`CONV_CORES-1:0][`CONV_UNITS-1:0][`CONV_WORD_ACC-1:0] sums;
  } conv_out_t;

  // what the output slice stores per entry
  typedef struct packed {
    conv_user_t user;
    conv_out_t  data;
  } conv_beat_t;

  typedef enum logic [1:0] {
    EMPTY,
    ONE,
    FULL
  } slice_state_t;

endpackage

// File: logic/mac_unit.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module mac_unit (
  input  logic                             aclk,
  input  logic                             reset,
  input  logic                             clken,
  input  logic signed [`CONV_WORD_IN-1:0]  pixel,
  input  logic signed [`CONV_WORD_IN-1:0]  weight,
  input  logic                             en,
  input  logic                             restart,
  output logic signed [`CONV_WORD_ACC-1:0] sum
);

  localparam int PROD_W = 2 * `CONV_WORD_IN;
  localparam int LAT = `CONV_LAT_MUL;

  logic signed [`CONV_WORD_IN-1:0]  pixel_q;
  logic signed [`CONV_WORD_IN-1:0]  weight_q;
  logic signed [PROD_W-1:0]         prod_q [LAT];
  logic [LAT:0]                     en_q;
  logic [LAT:0]                     restart_q;
  logic signed [`CONV_WORD_ACC-1:0] prod_ext;

  // full product sign extended to the accumulator
  assign prod_ext = {{(`CONV_WORD_ACC - PROD_W){prod_q[LAT-1][PROD_W-1]}}, prod_q[LAT-1]};

  // operand registers and multiplier pipeline
  always_ff @(posedge aclk) begin
    if (clken) begin
      pixel_q   <= pixel;
      weight_q  <= weight;
      prod_q[0] <= pixel_q * weight_q;
      for (int i = 1; i < LAT; i++) begin
        prod_q[i] <= prod_q[i-1];
      end
    end
  end

  // control shadow of the pipeline plus the accumulator
  always_ff @(posedge aclk) begin
    if (reset) begin
      en_q      <= '0;
      restart_q <= '0;
      sum       <= '0;
    end else if (clken) begin
      en_q      <= {en_q[LAT-1:0], en};
      restart_q <= {restart_q[LAT-1:0], restart};
      if (en_q[LAT]) begin
        if (restart_q[LAT]) begin
          sum <= prod_ext;
        end else begin
          sum <= sum + prod_ext;
        end
      end
    end
  end

endmodule

// File: tb/axis_conv_engine_assert.sv
`timescale 1ns/1ps

module axis_conv_engine_assert (
  input logic                 aclk,
  input logic                 reset,
  input logic                 m_valid,
  input logic                 m_ready,
  input logic                 m_last,
  input conv_pkg::conv_user_t m_user,
  input conv_pkg::conv_out_t  m_data
);

  // failure count read by the testbench at the end of the run
  int assert_fails = 0;

  // slice comes out of reset empty
  assert property (@(posedge aclk) reset |=> !m_valid)
    else begin
      $error("m_valid high in the cycle after reset");
      assert_fails++;
    end

  // a stalled beat holds its data
  assert property (@(posedge aclk) disable iff (reset)
                   m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_user))
    else begin
      $error("output beat changed while m_ready was low");
      assert_fails++;
    end

  // every output beat closes a group
  assert property (@(posedge aclk) disable iff (reset) m_last == m_valid)
    else begin
      $error("m_last differs from m_valid");
      assert_fails++;
    end

endmodule

bind axis_conv_engine axis_conv_engine_assert assert_i (
  .aclk    (aclk),
  .reset   (reset),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_last  (m_last),
  .m_user  (m_user),
  .m_data  (m_data)
);

// File: tb/conv_trace.txt
# I count last user pixel0 pixel1 pixel2 pixel3 weight0 weight1 (count copies sent back to back)
# E user sum[0][0..3] sum[1][0..3], all values signed decimal
# single-beat groups, the first one also times the latency
I 1 1 0 3 -2 5 -7 4 -3
E 0 12 -8 20 -28 -9 6 -15 21
I 1 1 3 -128 127 -1 0 -128 127
E 3 16384 -16256 128 0 -16256 16129 -127 0
I 1 1 2 10 20 -30 40 -5 6
E 2 -50 -100 150 -200 60 120 -180 240
# three beats, user comes from the last one
I 1 0 2 1 2 3 4 1 -1
I 1 0 0 -5 6 -7 8 2 3
I 1 1 1 9 -10 11 -12 -4 5
E 1 -45 54 -55 68 29 -34 31 -40
I 3 1 2 100 -100 50 -50 100 -100
E 2 30000 -30000 15000 -15000 -30000 30000 -15000 15000
# nine beats
I 1 0 3 1 -1 2 -4 -3 3
I 1 0 3 2 -2 2 -3 -2 3
I 1 0 3 3 -3 2 -2 -1 3
I 1 0 3 4 -4 2 -1 0 3
I 1 0 3 5 -5 2 0 1 3
I 1 0 3 6 -6 2 1 2 3
I 1 0 3 7 -7 2 2 3 3
I 1 0 3 8 -8 2 3 4 3
I 1 1 0 9 -9 2 4 5 3
E 0 105 -105 18 60 135 -135 54 0
# 520 large products wrap the 24-bit sums
I 520 1 1 -128 -128 127 127 -128 127
E 1 -8257536 -8257536 8324096 8324096 8324096 8324096 8387080 8387080
# fresh sum after the wrap
I 1 1 2 -1 -1 -1 -1 -1 -1
E 2 1 1 1 1 1 1 1 1

// File: tb/tb_axis_conv_engine.sv
`timescale 1ns/1ps
`include "conv_macros.svh"

module tb_axis_conv_engine;

  import conv_pkg::*;

  localparam int    TIMEOUT    = 1000;
  localparam int    IDLE_CHECK = 50;
  localparam int    LATENCY    = `CONV_LAT_MUL + 2;
  localparam string TRACE_FILE = "tb/conv_trace.txt";

  logic       aclk;
  logic       reset;
  logic       s_valid;
  logic       s_ready;
  logic       s_last;
  conv_user_t s_user;
  conv_in_t   s_data;
  logic       m_valid;
  logic       m_ready;
  logic       m_last;
  conv_user_t m_user;
  conv_out_t  m_data;

  // trace contents
  conv_in_t   in_data [$];
  conv_user_t in_user [$];
  logic       in_last [$];
  int         in_count [$];
  conv_out_t  exp_data [$];
  conv_user_t exp_user [$];

  int   cycle = 0;
  int   first_last_edge = -1;
  int   first_out_edge = -1;
  logic ready_random = 1'b0;
  logic outputs_done = 1'b0;

  axis_conv_engine dut_i (
    .aclk    (aclk),
    .reset   (reset),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_last  (s_last),
    .s_user  (s_user),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_last  (m_last),
    .m_user  (m_user),
    .m_data  (m_data)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // rising edge count read only at falling edges
  always @(posedge aclk) cycle <= cycle + 1;

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_sums(conv_out_t got, conv_out_t expected);
    for (int c = 0; c < `CONV_CORES; c++) begin
      for (int u = 0; u < `CONV_UNITS; u++) begin
        if (got.sums[c][u] !== expected.sums[c][u]) begin
          $display("FAILED at %0t: m_data.sums[%0d][%0d] = %0d, expected %0d", $time, c, u,
                   $signed(got.sums[c][u]), $signed(expected.sums[c][u]));
          abort_run();
        end
      end
    end
  endtask

  task automatic check_user(conv_user_t got, conv_user_t expected);
    if (got !== expected) begin
      $display("FAILED at %0t: m_user = %b, expected %b", $time, got, expected);
      abort_run();
    end
  endtask

  task automatic check_last(logic got, logic expected);
    if (got !== expected) begin
      $display("FAILED at %0t: m_last = %b, expected %b", $time, got, expected);
      abort_run();
    end
  endtask

  task automatic check_latency(int got, int expected);
    if (got != expected) begin
      $display("FAILED at %0t: m_valid latency = %0d, expected %0d", $time, got, expected);
      abort_run();
    end
  endtask

  task automatic load_trace();
    int        fd;
    int        n;
    int        v [9];
    string     line;
    string     body;
    conv_in_t  d;
    conv_out_t e;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("could not open the trace file %s", TRACE_FILE);
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;
      body = line.substr(1, line.len() - 1);
      n = $sscanf(body, "%d %d %d %d %d %d %d %d %d",
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
      if (n != 9) begin
        $display("malformed trace line: %s", line);
        abort_run();
      end
      if (line.getc(0) == "I") begin
        for (int u = 0; u < `CONV_UNITS; u++) d.pixels[u] = v[3 + u][`CONV_WORD_IN-1:0];
        for (int c = 0; c < `CONV_CORES; c++) d.weights[c] = v[7 + c][`CONV_WORD_IN-1:0];
        in_count.push_back(v[0]);
        in_last.push_back(v[1] != 0);
        in_user.push_back(v[2][1:0]);
        in_data.push_back(d);
      end else begin
        for (int c = 0; c < `CONV_CORES; c++) begin
          for (int u = 0; u < `CONV_UNITS; u++) begin
            e.sums[c][u] = v[1 + c * `CONV_UNITS + u][`CONV_WORD_ACC-1:0];
          end
        end
        exp_user.push_back(v[0][1:0]);
        exp_data.push_back(e);
      end
    end
    $fclose(fd);
  endtask

  // repeated copies of a line go back to back after a random gap
  task automatic send_beats();
    int gap;
    int waited;
    for (int n = 0; n < in_data.size(); n++) begin
      gap = $urandom % 3;
      repeat (gap) begin
        @(posedge aclk);
        #1;
      end
      for (int r = 0; r < in_count[n]; r++) begin
        s_valid = 1'b1;
        s_data  = in_data[n];
        s_user  = in_user[n];
        s_last  = in_last[n] && (r == in_count[n] - 1);
        waited  = 0;
        @(negedge aclk);
        while (!s_ready) begin
          waited++;
          if (waited > TIMEOUT) begin
            $display("s_ready stayed low for %0d cycles on input line %0d", TIMEOUT, n);
            abort_run();
          end
          @(negedge aclk);
        end
        // beat transfers on the coming edge
        if (s_last && first_last_edge < 0) first_last_edge = cycle + 1;
        @(posedge aclk);
        #1;
        s_valid = 1'b0;
        s_last  = 1'b0;
      end
    end
  endtask

  task automatic collect_outputs();
    int waited;
    for (int n = 0; n < exp_data.size(); n++) begin
      waited = 0;
      do begin
        @(negedge aclk);
        if (m_valid && first_out_edge < 0) first_out_edge = cycle;
        waited++;
        if (waited > TIMEOUT) begin
          $display("no output beat %0d within %0d cycles", n, TIMEOUT);
          abort_run();
        end
      end while (!(m_valid && m_ready));
      if (n == 0) begin
        check_latency(first_out_edge - first_last_edge, LATENCY);
        ready_random = 1'b1;
      end
      check_sums(m_data, exp_data[n]);
      check_user(m_user, exp_user[n]);
      check_last(m_last, 1'b1);
    end
    outputs_done = 1'b1;
  endtask

  // m_ready stays high until the first beat has been timed
  task automatic randomize_ready();
    while (!outputs_done) begin
      @(posedge aclk);
      #1;
      if (ready_random) m_ready = ($urandom % 3) != 0;
    end
  endtask

  initial begin
    reset   = 1'b1;
    s_valid = 1'b0;
    s_last  = 1'b0;
    s_user  = '0;
    s_data  = '0;
    m_ready = 1'b1;
    void'($urandom(61));
    load_trace();
    repeat (2) @(posedge aclk);
    #1;
    reset = 1'b0;
    fork
      send_beats();
      collect_outputs();
      randomize_ready();
    join
    repeat (IDLE_CHECK) begin
      @(negedge aclk);
      if (m_valid) begin
        $display("an output beat appeared after the last expected one");
        abort_run();
      end
    end
    if (dut_i.assert_i.assert_fails == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      $display("%0d protocol assertions failed", dut_i.assert_i.assert_fails);
      abort_run();
    end
  end

endmodule
